//--- Makefile
TOP := tb_ctrl_top

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 -f ctrl.f --top-module $(TOP) -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	@if grep -q "Some tests failed" sim.log; then exit 1; fi
	@grep -q "All tests passed" sim.log

clean:
	rm -rf obj_dir sim.log

//--- ctrl.f
rtl/ctrl_pkg.sv
rtl/ctrl_wb_decode.sv
rtl/ctrl_pending_track.sv
rtl/ctrl_main_fsm.sv
rtl/ctrl_top.sv
verif/tb_clk_gen.sv
verif/tb_ctrl_top.sv

//--- rtl/ctrl_main_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module ctrl_main_fsm #(
  parameter int unsigned IRQ_ID_W = 5
) (
  input  wire                     clk,
  input  wire                     rst_n,
  input  wire                     fetch_enable_i,
  input  wire                     mret_id_i,
  input  wire                     jump_id_i,
  input  wire                     branch_ex_i,
  input  wire                     if_valid_i,
  input  wire                     id_ready_i,
  input  wire                     irq_wu_i,
  input  wire                     vectored_i,
  input  wire                     pending_irq_i,
  input  wire                     irq_allowed_i,
  input  wire                     pending_nmi_i,
  input  wire                     nmi_is_store_i,
  input  wire                     halt_id_req_i,
  input  wire [IRQ_ID_W-1:0]      irq_id_i,
  input  wire                     minstret_stall_i,
  input  ctrl_pkg::stage_valid_t  stage_valid_i,
  input  ctrl_pkg::wb_evt_t       wb_evt_i,
  input  wire                     wb_valid_i,
  output ctrl_pkg::ctrl_out_t     ctrl_o,
  output logic                    nmi_taken_o
);

  import ctrl_pkg::*;

  ctrl_state_e state_q;
  ctrl_state_e state_d;

  // Blocks a second redirect to the same target while stalled
  logic branch_taken_q;
  logic branch_taken_d;

  logic jump_taken_id;
  logic branch_taken_ex;
  logic take_nmi;
  logic take_irq;

  // Oldest valid stage, one hot
  logic save_wb_sel;
  logic save_ex_sel;
  logic save_id_sel;
  logic save_if_sel;

  // Interrupt id widened to the cause field
  exc_code_t irq_code;

  assign irq_code = exc_code_t'(irq_id_i);

  // ID and EX inputs arrive already qualified by their own stage
  assign jump_taken_id   = (jump_id_i | mret_id_i) & ~branch_taken_q;
  assign branch_taken_ex = branch_ex_i & ~branch_taken_q;

  assign take_nmi = pending_nmi_i & irq_allowed_i;
  assign take_irq = pending_irq_i & irq_allowed_i;

  // IF PC is always valid, it is the next one to issue
  assign save_wb_sel = wb_valid_i;
  assign save_ex_sel = ~wb_valid_i & stage_valid_i.id_ex_valid;
  assign save_id_sel = ~wb_valid_i & ~stage_valid_i.id_ex_valid & stage_valid_i.if_id_valid;
  assign save_if_sel = ~wb_valid_i & ~stage_valid_i.id_ex_valid & ~stage_valid_i.if_id_valid;

  ////////////////////
  // Next state and outputs
  ////////////////////

  always_comb begin
    state_d        = state_q;
    branch_taken_d = branch_taken_q;

    ctrl_o.instr_req  = 1'b1;
    ctrl_o.ctrl_busy  = 1'b1;
    ctrl_o.pc_set     = 1'b0;
    ctrl_o.pc_mux     = PC_BOOT;
    ctrl_o.exc_pc_mux = EXC_PC_IRQ;

    ctrl_o.kill_if = 1'b0;
    ctrl_o.kill_id = 1'b0;
    ctrl_o.kill_ex = 1'b0;
    ctrl_o.kill_wb = 1'b0;

    // Hazards and blocked interrupts halt ID, minstret reads halt EX
    ctrl_o.halt_if = 1'b0;
    ctrl_o.halt_id = halt_id_req_i;
    ctrl_o.halt_ex = minstret_stall_i;
    ctrl_o.halt_wb = 1'b0;

    ctrl_o.csr_save_if      = 1'b0;
    ctrl_o.csr_save_id      = 1'b0;
    ctrl_o.csr_save_ex      = 1'b0;
    ctrl_o.csr_save_wb      = 1'b0;
    ctrl_o.csr_save_cause   = 1'b0;
    ctrl_o.csr_restore_mret = 1'b0;
    ctrl_o.csr_cause        = '0;

    ctrl_o.irq_ack = 1'b0;
    ctrl_o.irq_id  = '0;

    unique case (state_q)
      RESET: begin
        ctrl_o.instr_req = 1'b0;
        if (fetch_enable_i) begin
          state_d = BOOT_SET;
        end
      end
      // Registered boot redirect keeps fetch_enable_i off the PC path
      BOOT_SET: begin
        ctrl_o.pc_set = 1'b1;
        ctrl_o.pc_mux = PC_BOOT;
        state_d       = FUNCTIONAL;
      end
      FUNCTIONAL: begin
        if (take_nmi || take_irq) begin
          // Flush everything, the handler restarts from the oldest PC
          ctrl_o.kill_if        = 1'b1;
          ctrl_o.kill_id        = 1'b1;
          ctrl_o.kill_ex        = 1'b1;
          ctrl_o.kill_wb        = 1'b1;
          ctrl_o.pc_set         = 1'b1;
          ctrl_o.pc_mux         = PC_EXCEPTION;
          ctrl_o.csr_save_cause = 1'b1;
          ctrl_o.csr_save_wb    = save_wb_sel;
          ctrl_o.csr_save_ex    = save_ex_sel;
          ctrl_o.csr_save_id    = save_id_sel;
          ctrl_o.csr_save_if    = save_if_sel;
          ctrl_o.csr_cause.interrupt = 1'b1;
          if (take_nmi) begin
            ctrl_o.exc_pc_mux = EXC_PC_NMI;
            ctrl_o.csr_cause.exception_code = nmi_is_store_i ? INT_CAUSE_LSU_STORE_FAULT :
                                                               INT_CAUSE_LSU_LOAD_FAULT;
          end else begin
            ctrl_o.exc_pc_mux = EXC_PC_IRQ;
            ctrl_o.irq_ack    = 1'b1;
            ctrl_o.irq_id     = irq_code;
            ctrl_o.csr_cause.exception_code = irq_code;
          end
        end else begin
          if (wb_evt_i.exception) begin
            // WB write enables are already suppressed, so WB is not killed
            ctrl_o.kill_if        = 1'b1;
            ctrl_o.kill_id        = 1'b1;
            ctrl_o.kill_ex        = 1'b1;
            ctrl_o.pc_set         = 1'b1;
            ctrl_o.pc_mux         = PC_EXCEPTION;
            ctrl_o.exc_pc_mux     = EXC_PC_EXCEPTION;
            ctrl_o.csr_save_wb    = 1'b1;
            ctrl_o.csr_save_cause = 1'b1;
            ctrl_o.csr_cause.exception_code = wb_evt_i.exc_cause;
          end else if (wb_evt_i.wfi) begin
            // EX keeps moving so its bubble drains into WB
            ctrl_o.halt_if   = 1'b1;
            ctrl_o.halt_id   = 1'b1;
            ctrl_o.instr_req = 1'b0;
            state_d          = SLEEP;
          end else if (branch_taken_ex) begin
            ctrl_o.kill_if = 1'b1;
            ctrl_o.kill_id = 1'b1;
            ctrl_o.pc_set  = 1'b1;
            ctrl_o.pc_mux  = PC_BRANCH;
            branch_taken_d = 1'b1;
          end else if (jump_taken_id) begin
            ctrl_o.kill_if = 1'b1;
            ctrl_o.pc_set  = 1'b1;
            ctrl_o.pc_mux  = mret_id_i ? PC_MRET : PC_JUMP;
            branch_taken_d = 1'b1;
          end
          // mstatus and friends come back when mret retires
          ctrl_o.csr_restore_mret = wb_evt_i.mret_wb;
        end
      end
      SLEEP: begin
        ctrl_o.ctrl_busy = 1'b0;
        ctrl_o.instr_req = 1'b0;
        // Halting WB holds the whole pipe behind it
        ctrl_o.halt_wb   = 1'b1;
        if (irq_wu_i) begin
          ctrl_o.ctrl_busy = 1'b1;
          state_d          = FUNCTIONAL;
        end
      end
      default: begin
        ctrl_o.instr_req = 1'b0;
        state_d          = RESET;
      end
    endcase

    // New instruction leaves IF, redirects are allowed again
    if (branch_taken_q && if_valid_i && id_ready_i) begin
      branch_taken_d = 1'b0;
    end

    // Vector table index only for an acked interrupt in vectored mode
    ctrl_o.m_exc_vec_pc_mux = (vectored_i && ctrl_o.irq_ack) ? irq_code : '0;
    ctrl_o.pending_nmi      = pending_nmi_i;
  end

  assign nmi_taken_o = (state_q == FUNCTIONAL) & take_nmi;

  ////////////////////
  // State flops
  ////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q        <= RESET;
      branch_taken_q <= 1'b0;
    end else begin
      state_q        <= state_d;
      branch_taken_q <= branch_taken_d;
    end
  end

  // No redirect before the boot sequence has started
  assert property (@(posedge clk) disable iff (!rst_n)
    (state_q == RESET) |-> !ctrl_o.pc_set);

  // The CSR block saves exactly one PC per trap
  assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0({ctrl_o.csr_save_if, ctrl_o.csr_save_id, ctrl_o.csr_save_ex, ctrl_o.csr_save_wb}));

endmodule

`default_nettype wire

//--- rtl/ctrl_pending_track.sv
`timescale 1ns/1ps
`default_nettype none

module ctrl_pending_track (
  input  wire                   clk,
  input  wire                   rst_n,
  input  wire                   lsu_err_wb_i,
  input  wire                   rf_we_i,
  input  wire                   obi_data_req_i,
  input  wire                   ex_valid_i,
  input  wire                   wb_ready_i,
  input  wire                   irq_req_i,
  input  wire                   nmi_taken_i,
  input  ctrl_pkg::wb_evt_t     wb_evt_i,
  input  ctrl_pkg::byp_stall_t  byp_i,
  output logic                  pending_irq_o,
  output logic                  irq_allowed_o,
  output logic                  pending_nmi_o,
  output logic                  nmi_is_store_o,
  output logic                  halt_id_req_o
);

  // Sticky bus error from writeback
  logic nmi_pending_q;
  // 1 for a store, 0 for a load
  logic nmi_is_store_q;
  // Data request went out while the LSU instruction is still in EX
  logic obi_data_req_q;
  // LSU instruction leaves EX this cycle
  logic ex_to_wb;
  logic irq_allowed;
  logic hazard_stall;

  assign ex_to_wb = ex_valid_i & wb_ready_i;

  ////////////////////
  // NMI flag
  ////////////////////

  // First error wins, later errors are dropped until the NMI is taken
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      nmi_pending_q  <= 1'b0;
      nmi_is_store_q <= 1'b0;
    end else if (lsu_err_wb_i && !nmi_pending_q) begin
      nmi_pending_q  <= 1'b1;
      // Loads write the register file, stores do not
      nmi_is_store_q <= ~rf_we_i;
    end else if (nmi_taken_i) begin
      nmi_pending_q  <= 1'b0;
    end
  end

  // Outstanding data request tracking
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      obi_data_req_q <= 1'b0;
    end else if (obi_data_req_i && !ex_to_wb) begin
      obi_data_req_q <= 1'b1;
    end else if (ex_to_wb) begin
      obi_data_req_q <= 1'b0;
    end
  end

  ////////////////////
  // Interrupt gating
  ////////////////////

  // No interrupt while a load or store is committed to the bus
  assign irq_allowed = ~wb_evt_i.retire_lsu & ~obi_data_req_q;

  assign hazard_stall = byp_i.jr_stall | byp_i.load_stall | byp_i.csr_stall |
                        byp_i.wfi_stall;

  // Blocked requests halt ID so that an interruptible bubble reaches WB
  assign halt_id_req_o = hazard_stall |
                         (irq_req_i & ~irq_allowed) |
                         (nmi_pending_q & ~irq_allowed);

  assign pending_irq_o  = irq_req_i;
  assign irq_allowed_o  = irq_allowed;
  assign pending_nmi_o  = nmi_pending_q;
  assign nmi_is_store_o = nmi_is_store_q;

  // The FSM only takes an NMI that this block has flagged
  assert property (@(posedge clk) disable iff (!rst_n)
    nmi_taken_i |-> nmi_pending_q);

endmodule

`default_nettype wire

//--- rtl/ctrl_pkg.sv
`default_nettype none

package ctrl_pkg;

  ////////////////////
  // State and mux encodings
  ////////////////////

  // Controller FSM states
  typedef enum logic [1:0] {
    RESET      = 2'd0,
    BOOT_SET   = 2'd1,
    FUNCTIONAL = 2'd2,
    SLEEP      = 2'd3
  } ctrl_state_e;

  // Source of the next fetch PC
  typedef enum logic [2:0] {
    PC_BOOT      = 3'd0,
    PC_JUMP      = 3'd1,
    PC_MRET      = 3'd2,
    PC_BRANCH    = 3'd3,
    PC_EXCEPTION = 3'd4
  } pc_mux_e;

  // Handler base selection when pc_mux is PC_EXCEPTION
  typedef enum logic [1:0] {
    EXC_PC_EXCEPTION = 2'd0,
    EXC_PC_IRQ       = 2'd1,
    EXC_PC_NMI       = 2'd2
  } exc_pc_mux_e;

  ////////////////////
  // Cause codes
  ////////////////////

  typedef logic [7:0] exc_code_t;

  // Synchronous exceptions
  localparam exc_code_t EXC_CAUSE_INSTR_FAULT     = 8'd1;
  localparam exc_code_t EXC_CAUSE_INSTR_BUS_FAULT = 8'd1;
  localparam exc_code_t EXC_CAUSE_ILLEGAL_INSN    = 8'd2;
  localparam exc_code_t EXC_CAUSE_BREAKPOINT      = 8'd3;
  localparam exc_code_t EXC_CAUSE_ECALL_MMODE     = 8'd11;
  // NMI codes, reported with the interrupt bit set
  localparam exc_code_t INT_CAUSE_LSU_LOAD_FAULT  = 8'd128;
  localparam exc_code_t INT_CAUSE_LSU_STORE_FAULT = 8'd129;

  // mcause image
  typedef struct packed {
    logic      interrupt;
    exc_code_t exception_code;
  } csr_cause_t;

  ////////////////////
  // Pipeline side bundles
  ////////////////////

  // Flags of the instruction sitting in writeback
  typedef struct packed {
    logic instr_valid;
    logic instr_fault;
    logic bus_fault;
    logic illegal;
    logic ecall;
    logic ebrk;
    logic wfi;
    logic mret;
    logic lsu_en;
    logic rf_we;
  } wb_flags_t;

  // Valid bits of the IF/ID and ID/EX pipeline registers
  typedef struct packed {
    logic if_id_valid;
    logic id_ex_valid;
  } stage_valid_t;

  // Hazard stalls from the bypass logic
  typedef struct packed {
    logic jr_stall;
    logic load_stall;
    logic csr_stall;
    logic wfi_stall;
    logic minstret_stall;
  } byp_stall_t;

  // Writeback events, already qualified with instr_valid
  typedef struct packed {
    logic      exception;
    exc_code_t exc_cause;
    logic      wfi;
    logic      mret_wb;
    logic      retire_lsu;
  } wb_evt_t;

  // Everything the controller drives into the pipeline and CSRs
  typedef struct packed {
    logic        instr_req;
    logic        ctrl_busy;
    logic        pc_set;
    pc_mux_e     pc_mux;
    exc_pc_mux_e exc_pc_mux;
    logic        kill_if;
    logic        kill_id;
    logic        kill_ex;
    logic        kill_wb;
    logic        halt_if;
    logic        halt_id;
    logic        halt_ex;
    logic        halt_wb;
    logic        csr_save_if;
    logic        csr_save_id;
    logic        csr_save_ex;
    logic        csr_save_wb;
    logic        csr_save_cause;
    logic        csr_restore_mret;
    csr_cause_t  csr_cause;
    logic        irq_ack;
    exc_code_t   irq_id;
    exc_code_t   m_exc_vec_pc_mux;
    logic        pending_nmi;
  } ctrl_out_t;

endpackage

`default_nettype wire

//--- rtl/ctrl_top.sv
`timescale 1ns/1ps
`default_nettype none

module ctrl_top #(
  parameter int unsigned IRQ_ID_W = 5
) (
  input  wire                       clk,
  input  wire                       rst_n,
  input  wire                       fetch_enable_i,
  input  ctrl_pkg::byp_stall_t      byp_i,
  input  ctrl_pkg::stage_valid_t    stage_valid_i,
  input  ctrl_pkg::wb_flags_t       wb_i,
  input  wire                       mret_id_i,
  input  wire                       jump_id_i,
  input  wire                       branch_ex_i,
  input  wire                       obi_data_req_i,
  input  wire                       ex_valid_i,
  input  wire                       wb_ready_i,
  input  wire                       if_valid_i,
  input  wire                       id_ready_i,
  input  wire                       lsu_err_wb_i,
  input  wire                       irq_req_i,
  input  wire [IRQ_ID_W-1:0]        irq_id_i,
  input  wire                       irq_wu_i,
  input  wire                       vectored_i,
  output ctrl_pkg::ctrl_out_t       ctrl_o
);

  import ctrl_pkg::*;

  // Writeback events shared by both consumers
  wb_evt_t wb_evt;

  // Interrupt bookkeeping towards the FSM
  logic pending_irq;
  logic irq_allowed;
  logic pending_nmi;
  logic nmi_is_store;
  logic halt_id_req;
  // Back from the FSM, clears the sticky NMI
  logic nmi_taken;

  ctrl_wb_decode wb_decode_inst (
    .wb_i     (wb_i),
    .wb_evt_o (wb_evt)
  );

  ctrl_pending_track pending_track_inst (
    .clk            (clk),
    .rst_n          (rst_n),
    .lsu_err_wb_i   (lsu_err_wb_i),
    .rf_we_i        (wb_i.rf_we),
    .obi_data_req_i (obi_data_req_i),
    .ex_valid_i     (ex_valid_i),
    .wb_ready_i     (wb_ready_i),
    .irq_req_i      (irq_req_i),
    .nmi_taken_i    (nmi_taken),
    .wb_evt_i       (wb_evt),
    .byp_i          (byp_i),
    .pending_irq_o  (pending_irq),
    .irq_allowed_o  (irq_allowed),
    .pending_nmi_o  (pending_nmi),
    .nmi_is_store_o (nmi_is_store),
    .halt_id_req_o  (halt_id_req)
  );

  ctrl_main_fsm #(
    .IRQ_ID_W (IRQ_ID_W)
  ) main_fsm_inst (
    .clk              (clk),
    .rst_n            (rst_n),
    .fetch_enable_i   (fetch_enable_i),
    .mret_id_i        (mret_id_i),
    .jump_id_i        (jump_id_i),
    .branch_ex_i      (branch_ex_i),
    .if_valid_i       (if_valid_i),
    .id_ready_i       (id_ready_i),
    .irq_wu_i         (irq_wu_i),
    .vectored_i       (vectored_i),
    .pending_irq_i    (pending_irq),
    .irq_allowed_i    (irq_allowed),
    .pending_nmi_i    (pending_nmi),
    .nmi_is_store_i   (nmi_is_store),
    .halt_id_req_i    (halt_id_req),
    .irq_id_i         (irq_id_i),
    .minstret_stall_i (byp_i.minstret_stall),
    .stage_valid_i    (stage_valid_i),
    .wb_evt_i         (wb_evt),
    .wb_valid_i       (wb_i.instr_valid),
    .ctrl_o           (ctrl_o),
    .nmi_taken_o      (nmi_taken)
  );

endmodule

`default_nettype wire

//--- rtl/ctrl_wb_decode.sv
`timescale 1ns/1ps
`default_nettype none

module ctrl_wb_decode (
  input  ctrl_pkg::wb_flags_t wb_i,
  output ctrl_pkg::wb_evt_t   wb_evt_o
);

  import ctrl_pkg::*;

  // Any trap source seen on the instruction, before qualification
  logic fault_any;
  // Cause chosen by fixed priority
  exc_code_t cause;

  assign fault_any = wb_i.instr_fault | wb_i.bus_fault | wb_i.illegal |
                     wb_i.ecall | wb_i.ebrk;

  ////////////////////
  // Cause priority
  ////////////////////

  // Fetch side faults first, then decode faults, then environment calls
  always_comb begin
    if (wb_i.instr_fault) begin
      cause = EXC_CAUSE_INSTR_FAULT;
    end else if (wb_i.bus_fault) begin
      cause = EXC_CAUSE_INSTR_BUS_FAULT;
    end else if (wb_i.illegal) begin
      cause = EXC_CAUSE_ILLEGAL_INSN;
    end else if (wb_i.ecall) begin
      cause = EXC_CAUSE_ECALL_MMODE;
    end else if (wb_i.ebrk) begin
      cause = EXC_CAUSE_BREAKPOINT;
    end else begin
      cause = '0;
    end
  end

  ////////////////////
  // Qualified events
  ////////////////////

  // Bubbles in writeback never raise an event
  assign wb_evt_o.exception  = wb_i.instr_valid & fault_any;
  assign wb_evt_o.exc_cause  = cause;
  assign wb_evt_o.wfi        = wb_i.instr_valid & wb_i.wfi;
  assign wb_evt_o.mret_wb    = wb_i.instr_valid & wb_i.mret;
  // Load or store still waiting for its response, not interruptible
  assign wb_evt_o.retire_lsu = wb_i.instr_valid & wb_i.lsu_en;

endmodule

`default_nettype wire

//--- verif/ctrl_stimulus.txt
// Inputs: fe jmp mret br ifv idr oreq exv wbr lerr irq id wu vec sv wb byp
// Expected: mask req busy set pmux emux kill halt save scs rst cause ack iid vec nmi
0 0 0 0 0 0 0 0 0 0 0 00 0 0 0 000 00  7fe7 0 1 0 0 1 0 0 0 0 0 000 0 00 00 0
0 0 0 0 0 0 0 0 0 0 0 00 0 0 0 000 00  7fe7 0 1 0 0 1 0 0 0 0 0 000 0 00 00 0
1 0 0 0 0 0 0 0 0 0 0 00 0 0 0 000 00  7fe7 0 1 0 0 1 0 0 0 0 0 000 0 00 00 0
1 0 0 0 0 0 0 0 0 0 0 00 0 0 0 000 00  7fef 1 1 1 0 1 0 0 0 0 0 000 0 00 00 0
1 0 0 0 0 0 0 0 0 0 0 00 0 0 0 000 00  7fe7 1 1 0 0 1 0 0 0 0 0 000 0 00 00 0
1 0 0 0 0 0 0 0 0 0 0 00 0 0 3 270 00  7fff 1 1 1 4 0 e 0 1 1 0 002 0 00 00 0
1 0 0 0 0 0 0 0 0 0 0 00 0 0 3 2a0 00  7fff 1 1 1 4 0 e 0 1 1 0 001 0 00 00 0
1 0 0 0 0 0 0 0 0 0 0 00 0 0 3 230 00  7fff 1 1 1 4 0 e 0 1 1 0 00b 0 00 00 0
1 0 0 0 0 0 0 0 0 0 0 00 0 0 3 070 00  7fe7 1 1 0 0 1 0 0 0 0 0 000 0 00 00 0
1 0 0 0 0 0 0 0 0 0 1 05 0 0 3 202 00  7fe7 1 1 0 0 1 0 4 0 0 0 000 0 00 00 0
1 0 0 0 0 0 0 0 0 0 1 05 0 0 3 000 00  7fff 1 1 1 4 1 f 0 2 1 0 105 1 05 00 0
1 0 0 0 0 0 0 0 0 0 1 13 0 1 2 000 00  7fff 1 1 1 4 1 f 0 4 1 0 113 1 13 13 0
1 0 0 0 0 0 0 0 0 0 1 07 0 1 0 200 00  7fff 1 1 1 4 1 f 0 1 1 0 107 1 07 07 0
1 0 0 0 0 0 0 0 0 0 1 02 0 0 0 000 00  7fff 1 1 1 4 1 f 0 8 1 0 102 1 02 00 0
1 0 0 0 0 0 1 0 0 0 0 00 0 0 0 000 00  7fe7 1 1 0 0 1 0 0 0 0 0 000 0 00 00 0
1 0 0 0 0 0 0 1 1 0 1 03 0 0 0 000 00  7fe7 1 1 0 0 1 0 4 0 0 0 000 0 00 00 0
1 0 0 0 0 0 0 0 0 0 1 03 0 0 0 000 00  7fff 1 1 1 4 1 f 0 8 1 0 103 1 03 00 0
1 0 0 0 0 0 0 0 0 1 0 00 0 0 0 202 00  7fe7 1 1 0 0 1 0 0 0 0 0 000 0 00 00 0
1 0 0 0 0 0 0 0 0 0 1 04 0 0 0 202 00  7fe7 1 1 0 0 1 0 4 0 0 0 000 0 00 00 1
1 0 0 0 0 0 0 0 0 0 1 04 0 0 0 000 00  7fff 1 1 1 4 2 f 0 8 1 0 181 0 00 00 1
1 0 0 0 0 0 0 0 0 0 0 00 0 0 0 000 00  7fe7 1 1 0 0 1 0 0 0 0 0 000 0 00 00 0
1 0 0 0 0 0 0 0 0 1 0 00 0 0 0 203 00  7fe7 1 1 0 0 1 0 0 0 0 0 000 0 00 00 0
1 0 0 0 0 0 0 0 0 1 0 00 0 0 1 000 00  7fff 1 1 1 4 2 f 0 2 1 0 180 0 00 00 1
1 0 0 0 0 0 0 0 0 0 0 00 0 0 0 000 00  7fe7 1 1 0 0 1 0 0 0 0 0 000 0 00 00 0
1 0 0 0 0 0 0 0 0 0 0 00 0 0 0 208 00  7fe7 0 1 0 0 1 0 c 0 0 0 000 0 00 00 0
1 0 0 0 0 0 0 0 0 0 0 00 0 0 0 000 00  7fe7 0 0 0 0 1 0 1 0 0 0 000 0 00 00 0
1 0 0 0 0 0 0 0 0 0 0 00 0 0 0 000 00  7fe7 0 0 0 0 1 0 1 0 0 0 000 0 00 00 0
1 0 0 0 0 0 0 0 0 0 0 00 1 0 0 000 00  7fe7 0 1 0 0 1 0 1 0 0 0 000 0 00 00 0
1 0 0 0 0 0 0 0 0 0 0 00 0 0 0 000 00  7fe7 1 1 0 0 1 0 0 0 0 0 000 0 00 00 0
1 0 0 1 0 0 0 0 0 0 0 00 0 0 0 000 00  7fef 1 1 1 3 1 c 0 0 0 0 000 0 00 00 0
1 1 0 1 0 0 0 0 0 0 0 00 0 0 0 000 00  7fe7 1 1 0 0 1 0 0 0 0 0 000 0 00 00 0
1 1 0 0 1 1 0 0 0 0 0 00 0 0 0 000 00  7fe7 1 1 0 0 1 0 0 0 0 0 000 0 00 00 0
1 1 0 0 0 0 0 0 0 0 0 00 0 0 0 000 00  7fef 1 1 1 1 1 8 0 0 0 0 000 0 00 00 0
1 1 0 0 0 0 0 0 0 0 0 00 0 0 0 000 00  7fe7 1 1 0 0 1 0 0 0 0 0 000 0 00 00 0
1 0 0 0 1 1 0 0 0 0 0 00 0 0 0 000 00  7fe7 1 1 0 0 1 0 0 0 0 0 000 0 00 00 0
1 0 1 0 0 0 0 0 0 0 0 00 0 0 0 000 00  7fef 1 1 1 2 1 8 0 0 0 0 000 0 00 00 0
1 0 0 0 1 1 0 0 0 0 0 00 0 0 0 204 00  7fe7 1 1 0 0 1 0 0 0 0 1 000 0 00 00 0
1 0 0 0 0 0 0 0 0 0 0 00 0 0 0 000 09  7fe7 1 1 0 0 1 0 6 0 0 0 000 0 00 00 0
1 0 0 1 0 0 0 0 0 0 0 00 0 0 0 240 00  7fff 1 1 1 4 0 e 0 1 1 0 002 0 00 00 0
1 0 0 0 0 0 0 0 0 0 0 00 0 0 0 000 00  7fe7 1 1 0 0 1 0 0 0 0 0 000 0 00 00 0

//--- verif/tb_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
  parameter int RESET_CYCLES = 16
) (
  output logic clk_o,
  output logic rst_n_o
);

  // 10 ns period
  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;
  end

  // Reset released just after a rising edge
  initial begin
    rst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    #1 rst_n_o = 1'b1;
  end

endmodule

`default_nettype wire

//--- verif/tb_ctrl_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_ctrl_top;

  import ctrl_pkg::*;

  localparam int NUM_VECS     = 40;
  localparam int NUM_COLS     = 33;
  localparam int RESET_CYCLES = 16;
  // Reset, every vector and some slack, all at 10 ns
  localparam time TIMEOUT = (RESET_CYCLES + NUM_VECS + 10) * 10ns;

  logic clk;
  logic rst_n;

  logic         fetch_enable_i;
  byp_stall_t   byp_i;
  stage_valid_t stage_valid_i;
  wb_flags_t    wb_i;
  logic         mret_id_i;
  logic         jump_id_i;
  logic         branch_ex_i;
  logic         obi_data_req_i;
  logic         ex_valid_i;
  logic         wb_ready_i;
  logic         if_valid_i;
  logic         id_ready_i;
  logic         lsu_err_wb_i;
  logic         irq_req_i;
  logic [4:0]   irq_id_i;
  logic         irq_wu_i;
  logic         vectored_i;
  ctrl_out_t    ctrl_o;

  // One word per column, NUM_COLS words per vector
  logic [15:0] stim_mem [0:NUM_VECS*NUM_COLS-1];
  int          cur_vec;
  int          error_count;
  ctrl_out_t   exp_out;
  logic [15:0] exp_mask;

  tb_clk_gen #(.RESET_CYCLES(RESET_CYCLES)) clk_gen_inst (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  ctrl_top #(.IRQ_ID_W(5)) ctrl_top_inst (
    .clk (clk), .rst_n (rst_n), .fetch_enable_i (fetch_enable_i), .byp_i (byp_i),
    .stage_valid_i (stage_valid_i), .wb_i (wb_i), .mret_id_i (mret_id_i),
    .jump_id_i (jump_id_i), .branch_ex_i (branch_ex_i), .obi_data_req_i (obi_data_req_i),
    .ex_valid_i (ex_valid_i), .wb_ready_i (wb_ready_i), .if_valid_i (if_valid_i),
    .id_ready_i (id_ready_i), .lsu_err_wb_i (lsu_err_wb_i), .irq_req_i (irq_req_i),
    .irq_id_i (irq_id_i), .irq_wu_i (irq_wu_i), .vectored_i (vectored_i), .ctrl_o (ctrl_o)
  );

  ////////////////////
  // Compare tasks
  ////////////////////

  task automatic report_mismatch(input string name, input logic [15:0] exp_v,
                                 input logic [15:0] act_v);
    error_count++;
    $display("[ERROR] t=%0t vec=%0d state=%s %s exp=%h act=%h", $time, cur_vec,
             ctrl_top_inst.main_fsm_inst.state_q.name(), name, exp_v, act_v);
    $display("Some tests failed");
    $fatal(1, "Mismatch on %s", name);
  endtask

  task automatic check_pc_mux(input pc_mux_e act, input pc_mux_e exp);
    if (act !== exp) begin
      error_count++;
      $display("[ERROR] t=%0t vec=%0d ctrl_o.pc_mux exp=%s act=%s", $time, cur_vec,
               exp.name(), act.name());
      $display("Some tests failed");
      $fatal(1, "Wrong PC source");
    end
  endtask

  // Mask bit per field, see the column list in the stimulus file
  task automatic check_ctrl(input ctrl_out_t act, input ctrl_out_t exp, input logic [15:0] mask);
    if (mask[0] && act.instr_req !== exp.instr_req)
      report_mismatch("ctrl_o.instr_req", 16'(exp.instr_req), 16'(act.instr_req));
    if (mask[1] && act.ctrl_busy !== exp.ctrl_busy)
      report_mismatch("ctrl_o.ctrl_busy", 16'(exp.ctrl_busy), 16'(act.ctrl_busy));
    if (mask[2] && act.pc_set !== exp.pc_set)
      report_mismatch("ctrl_o.pc_set", 16'(exp.pc_set), 16'(act.pc_set));
    if (mask[3])
      check_pc_mux(act.pc_mux, exp.pc_mux);
    if (mask[4] && act.exc_pc_mux !== exp.exc_pc_mux)
      report_mismatch("ctrl_o.exc_pc_mux", 16'(exp.exc_pc_mux), 16'(act.exc_pc_mux));
    if (mask[5] && {act.kill_if, act.kill_id, act.kill_ex, act.kill_wb} !==
                   {exp.kill_if, exp.kill_id, exp.kill_ex, exp.kill_wb})
      report_mismatch("ctrl_o.kill_if/id/ex/wb",
                      16'({exp.kill_if, exp.kill_id, exp.kill_ex, exp.kill_wb}),
                      16'({act.kill_if, act.kill_id, act.kill_ex, act.kill_wb}));
    if (mask[6] && {act.halt_if, act.halt_id, act.halt_ex, act.halt_wb} !==
                   {exp.halt_if, exp.halt_id, exp.halt_ex, exp.halt_wb})
      report_mismatch("ctrl_o.halt_if/id/ex/wb",
                      16'({exp.halt_if, exp.halt_id, exp.halt_ex, exp.halt_wb}),
                      16'({act.halt_if, act.halt_id, act.halt_ex, act.halt_wb}));
    if (mask[7] && {act.csr_save_if, act.csr_save_id, act.csr_save_ex, act.csr_save_wb} !==
                   {exp.csr_save_if, exp.csr_save_id, exp.csr_save_ex, exp.csr_save_wb})
      report_mismatch("ctrl_o.csr_save_if/id/ex/wb",
                      16'({exp.csr_save_if, exp.csr_save_id, exp.csr_save_ex, exp.csr_save_wb}),
                      16'({act.csr_save_if, act.csr_save_id, act.csr_save_ex, act.csr_save_wb}));
    if (mask[8] && act.csr_save_cause !== exp.csr_save_cause)
      report_mismatch("ctrl_o.csr_save_cause", 16'(exp.csr_save_cause), 16'(act.csr_save_cause));
    if (mask[9] && act.csr_restore_mret !== exp.csr_restore_mret)
      report_mismatch("ctrl_o.csr_restore_mret", 16'(exp.csr_restore_mret),
                      16'(act.csr_restore_mret));
    if (mask[10] && act.csr_cause !== exp.csr_cause)
      report_mismatch("ctrl_o.csr_cause", 16'(exp.csr_cause), 16'(act.csr_cause));
    if (mask[11] && act.irq_ack !== exp.irq_ack)
      report_mismatch("ctrl_o.irq_ack", 16'(exp.irq_ack), 16'(act.irq_ack));
    if (mask[12] && act.irq_id !== exp.irq_id)
      report_mismatch("ctrl_o.irq_id", 16'(exp.irq_id), 16'(act.irq_id));
    if (mask[13] && act.m_exc_vec_pc_mux !== exp.m_exc_vec_pc_mux)
      report_mismatch("ctrl_o.m_exc_vec_pc_mux", 16'(exp.m_exc_vec_pc_mux),
                      16'(act.m_exc_vec_pc_mux));
    if (mask[14] && act.pending_nmi !== exp.pending_nmi)
      report_mismatch("ctrl_o.pending_nmi", 16'(exp.pending_nmi), 16'(act.pending_nmi));
  endtask

  ////////////////////
  // Vector handling
  ////////////////////

  task automatic drive_vector(input int v);
    int b;
    b = v * NUM_COLS;
    fetch_enable_i = stim_mem[b][0];
    jump_id_i      = stim_mem[b+1][0];
    mret_id_i      = stim_mem[b+2][0];
    branch_ex_i    = stim_mem[b+3][0];
    if_valid_i     = stim_mem[b+4][0];
    id_ready_i     = stim_mem[b+5][0];
    obi_data_req_i = stim_mem[b+6][0];
    ex_valid_i     = stim_mem[b+7][0];
    wb_ready_i     = stim_mem[b+8][0];
    lsu_err_wb_i   = stim_mem[b+9][0];
    irq_req_i      = stim_mem[b+10][0];
    irq_id_i       = stim_mem[b+11][4:0];
    irq_wu_i       = stim_mem[b+12][0];
    vectored_i     = stim_mem[b+13][0];
    stage_valid_i  = stage_valid_t'(stim_mem[b+14][1:0]);
    wb_i           = wb_flags_t'(stim_mem[b+15][9:0]);
    byp_i          = byp_stall_t'(stim_mem[b+16][4:0]);
  endtask

  // Unpack the expected columns into the DUT's own output type
  task automatic load_expected(input int v);
    int b;
    b = v * NUM_COLS;
    exp_mask = stim_mem[b+17];
    exp_out  = '0;
    exp_out.instr_req  = stim_mem[b+18][0];
    exp_out.ctrl_busy  = stim_mem[b+19][0];
    exp_out.pc_set     = stim_mem[b+20][0];
    exp_out.pc_mux     = pc_mux_e'(stim_mem[b+21][2:0]);
    exp_out.exc_pc_mux = exc_pc_mux_e'(stim_mem[b+22][1:0]);
    {exp_out.kill_if, exp_out.kill_id, exp_out.kill_ex, exp_out.kill_wb} = stim_mem[b+23][3:0];
    {exp_out.halt_if, exp_out.halt_id, exp_out.halt_ex, exp_out.halt_wb} = stim_mem[b+24][3:0];
    {exp_out.csr_save_if, exp_out.csr_save_id,
     exp_out.csr_save_ex, exp_out.csr_save_wb} = stim_mem[b+25][3:0];
    exp_out.csr_save_cause   = stim_mem[b+26][0];
    exp_out.csr_restore_mret = stim_mem[b+27][0];
    exp_out.csr_cause        = csr_cause_t'(stim_mem[b+28][8:0]);
    exp_out.irq_ack          = stim_mem[b+29][0];
    exp_out.irq_id           = stim_mem[b+30][7:0];
    exp_out.m_exc_vec_pc_mux = stim_mem[b+31][7:0];
    exp_out.pending_nmi      = stim_mem[b+32][0];
  endtask

  initial begin
    // Quiet inputs during reset
    fetch_enable_i = 1'b0;
    byp_i          = '0;
    stage_valid_i  = '0;
    wb_i           = '0;
    mret_id_i      = 1'b0;
    jump_id_i      = 1'b0;
    branch_ex_i    = 1'b0;
    obi_data_req_i = 1'b0;
    ex_valid_i     = 1'b0;
    wb_ready_i     = 1'b0;
    if_valid_i     = 1'b0;
    id_ready_i     = 1'b0;
    lsu_err_wb_i   = 1'b0;
    irq_req_i      = 1'b0;
    irq_id_i       = '0;
    irq_wu_i       = 1'b0;
    vectored_i     = 1'b0;
    error_count    = 0;
    cur_vec        = 0;
    $readmemh("verif/ctrl_stimulus.txt", stim_mem);
    wait (rst_n === 1'b1);
    // Drive 1 ns after the edge, sample 1 ns before the next one
    for (int v = 0; v < NUM_VECS; v++) begin
      @(posedge clk);
      #1;
      cur_vec = v;
      drive_vector(v);
      load_expected(v);
      #8;
      check_ctrl(ctrl_o, exp_out, exp_mask);
    end
    if (error_count == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(TIMEOUT);
    $display("Watchdog expired before all vectors were applied");
    $display("Some tests failed");
    $fatal(1, "Timeout");
  end

endmodule

`default_nettype wire
